//--- phoneme_narrator.f
design/narrator_pkg.sv
design/rate_pkg.sv
design/word_fetch_if.sv
design/flash_reader.sv
design/sample_unpacker.sv
design/sample_rate_timer.sv
design/playback_fsm.sv
design/phoneme_narrator.sv
sim/tb_phoneme_narrator.sv

//--- Bender.yml
package:
  name: phoneme_narrator

sources:
  - files:
      - design/narrator_pkg.sv
      - design/rate_pkg.sv
      - design/word_fetch_if.sv
      - design/flash_reader.sv
      - design/sample_unpacker.sv
      - design/sample_rate_timer.sv
      - design/playback_fsm.sv
      - design/phoneme_narrator.sv

  - target: simulation
    files:
      - sim/tb_phoneme_narrator.sv

//--- sim/tb_phoneme_narrator.sv
`timescale 1ns/1ps

module tb_phoneme_narrator;

  logic                                CLK_50M;
  logic                                arst_n;
  logic                                play;
  logic [narrator_pkg::phoneme_w-1:0]  phoneme_sel;
  logic                                speed_up;
  logic                                speed_down;
  logic                                speed_rst;
  logic                                flash_read;
  logic [narrator_pkg::addr_w-1:0]     flash_address;
  logic                                flash_waitrequest = 1'b1;
  logic [narrator_pkg::word_w-1:0]     flash_readdata = '0;
  logic                                flash_readdatavalid = 1'b0;
  logic [narrator_pkg::sample_w-1:0]   sample_out;
  logic                                sample_valid;
  logic                                busy;
  logic                                done;
  logic [rate_pkg::div_w-1:0]          rate_divisor;

  // Flash model state and logs
  logic [31:0]                      lfsr_state = 32'hd015be5c;
  int                               wait_bits;
  int                               wait_left;
  logic                             in_read = 1'b0;
  logic                             stalled = 1'b0;
  logic [narrator_pkg::addr_w-1:0]  stall_addr;
  logic [31:0]                      word_log [$];
  logic [narrator_pkg::addr_w-1:0]  addr_log [$];
  logic [7:0]                       sample_log [$];
  int                               sample_cycle [$];
  int                               done_count;
  int                               read_cycles;
  int                               cycle_count = 0;
  int                               cycle_limit;

  phoneme_narrator UUT (.*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==============================
  // Helpers
  // ==============================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'hd000_0001 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic int words_in(input int sel);
    return int'(narrator_pkg::phoneme_end[sel]) - int'(narrator_pkg::phoneme_start[sel]) + 1;
  endfunction

  task automatic compare_values(input string test_name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
      $display("Test failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // ==============================
  // Flash model and monitors
  // ==============================

  always @(posedge CLK_50M)
  begin : flash_model
    logic [31:0] bits;
    flash_readdatavalid <= 1'b0;
    // A stalled read must hold its address
    if (stalled)
    begin
      compare_values("addr_stable", 32'd1, {31'd0, flash_read});
      compare_values("addr_stable", stall_addr, flash_address);
    end
    stalled = flash_read && flash_waitrequest;
    stall_addr = flash_address;
    if (flash_read && flash_waitrequest)
    begin
      if (!in_read)
      begin
        in_read = 1'b1;
        take_bits(wait_bits, bits);
        wait_left = int'(bits);
      end
      if (wait_left == 0)
        flash_waitrequest <= 1'b0;
      else
        wait_left = wait_left - 1;
    end
    else if (flash_read)
    begin
      // Read accepted, data returns next cycle
      in_read = 1'b0;
      flash_waitrequest <= 1'b1;
      take_bits(32, bits);
      flash_readdata <= bits;
      flash_readdatavalid <= 1'b1;
      word_log.push_back(bits);
      addr_log.push_back(flash_address);
    end
  end

  always @(posedge CLK_50M)
  begin
    if (sample_valid)
    begin
      sample_log.push_back(sample_out);
      sample_cycle.push_back(cycle_count);
    end
    if (done)
      done_count = done_count + 1;
    if (flash_read)
      read_cycles = read_cycles + 1;
  end

  always @(posedge CLK_50M)
  begin
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
    else
    begin
      cycle_count <= cycle_count + 1;
    end
  end

  // ==============================
  // Tests
  // ==============================

  task automatic start_play(input int sel);
    word_log.delete();
    addr_log.delete();
    sample_log.delete();
    sample_cycle.delete();
    done_count = 0;
    read_cycles = 0;
    @(posedge CLK_50M);
    play <= 1'b1;
    phoneme_sel <= narrator_pkg::phoneme_w'(sel);
    @(posedge CLK_50M);
    play <= 1'b0;
    do @(posedge CLK_50M); while (!done);
    compare_values("busy_during_play", 32'd1, {31'd0, busy});
    repeat (2) @(posedge CLK_50M);
    compare_values("busy_after_done", 32'd0, {31'd0, busy});
  endtask

  task automatic check_reset_state();
    compare_values("reset_state", 32'd0, {31'd0, busy});
    compare_values("reset_state", 32'd0, {31'd0, done});
    compare_values("reset_state", 32'd0, {31'd0, flash_read});
    compare_values("reset_state", 32'd0, {31'd0, sample_valid});
    compare_values("reset_state", rate_pkg::default_divisor, rate_divisor);
  endtask

  task automatic play_and_check(input string test_name, input int sel, input int stall_bits);
    int n_words;
    logic [31:0] w;
    n_words = words_in(sel);
    wait_bits = stall_bits;
    start_play(sel);
    compare_values(test_name, 32'd1, done_count);
    compare_values(test_name, n_words, addr_log.size());
    compare_values(test_name, n_words * narrator_pkg::bytes_per_word, sample_log.size());
    for (int k = 0; k < n_words; k++)
    begin
      compare_values(test_name, narrator_pkg::phoneme_start[sel] + k, addr_log[k]);
      w = word_log[k];
      // Least significant byte plays first
      for (int b = 0; b < narrator_pkg::bytes_per_word; b++)
        compare_values(test_name, w[b*8 +: 8], sample_log[k*4 + b]);
    end
  endtask

  task automatic check_silent(input int sel);
    start_play(sel);
    compare_values("silent", 32'd1, done_count);
    compare_values("silent", 32'd0, read_cycles);
    compare_values("silent", 32'd0, sample_log.size());
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic rst);
    @(posedge CLK_50M);
    speed_up <= up;
    speed_down <= down;
    speed_rst <= rst;
    @(posedge CLK_50M);
    speed_up <= 1'b0;
    speed_down <= 1'b0;
    speed_rst <= 1'b0;
    @(posedge CLK_50M);
  endtask

  task automatic check_rate_limits();
    int exp_div;
    exp_div = rate_pkg::default_divisor;
    while (exp_div > rate_pkg::min_divisor)
    begin
      pulse_speed(1'b1, 1'b0, 1'b0);
      exp_div = exp_div - rate_pkg::divisor_step;
      if (exp_div < rate_pkg::min_divisor)
        exp_div = rate_pkg::min_divisor;
      compare_values("rate_limits", exp_div, rate_divisor);
    end
    pulse_speed(1'b1, 1'b0, 1'b0);
    compare_values("rate_limits", rate_pkg::min_divisor, rate_divisor);
    while (exp_div < rate_pkg::max_divisor)
    begin
      pulse_speed(1'b0, 1'b1, 1'b0);
      exp_div = exp_div + rate_pkg::divisor_step;
      if (exp_div > rate_pkg::max_divisor)
        exp_div = rate_pkg::max_divisor;
      compare_values("rate_limits", exp_div, rate_divisor);
    end
    pulse_speed(1'b0, 1'b1, 1'b0);
    compare_values("rate_limits", rate_pkg::max_divisor, rate_divisor);
    // Reset wins over a simultaneous up
    pulse_speed(1'b1, 1'b0, 1'b1);
    compare_values("rate_limits", rate_pkg::default_divisor, rate_divisor);
  endtask

  task automatic check_rate_spacing();
    int new_div;
    int gap;
    // Slower than the default, so the old rate would show up as short gaps
    repeat (20) pulse_speed(1'b0, 1'b1, 1'b0);
    new_div = rate_pkg::default_divisor + 20 * rate_pkg::divisor_step;
    compare_values("rate_spacing", new_div, rate_divisor);
    play_and_check("rate_spacing", 1, 2);
    for (int i = 1; i < sample_cycle.size(); i++)
    begin
      gap = sample_cycle[i] - sample_cycle[i-1];
      compare_values("rate_spacing", 32'd1, {31'd0, gap >= new_div});
    end
  endtask

  initial
  begin
    arst_n = 1'b0;
    play = 1'b0;
    phoneme_sel = '0;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_rst = 1'b0;
    wait_bits = 2;
    cycle_limit = 2 * (words_in(0) + words_in(4) + words_in(1)) * narrator_pkg::bytes_per_word
                  * (int'(rate_pkg::max_divisor) + 20);
    repeat (10) @(posedge CLK_50M);
    arst_n <= 1'b1;
    @(posedge CLK_50M);
    check_reset_state();
    play_and_check("play_phoneme_0", 0, 2);
    play_and_check("stalled_reads", 4, 4);
    check_silent(narrator_pkg::phoneme_count);
    check_silent(255);
    check_rate_limits();
    check_rate_spacing();
    $display("Test passed");
    $finish;
  end

endmodule

//--- design/phoneme_narrator.sv
`timescale 1ns/1ps

module phoneme_narrator (
  input  logic                                CLK_50M,
  input  logic                                arst_n,
  input  logic                                play,
  input  logic [narrator_pkg::phoneme_w-1:0]  phoneme_sel,
  input  logic                                speed_up,
  input  logic                                speed_down,
  input  logic                                speed_rst,
  output logic                                flash_read,
  output logic [narrator_pkg::addr_w-1:0]     flash_address,
  input  logic                                flash_waitrequest,
  input  logic [narrator_pkg::word_w-1:0]     flash_readdata,
  input  logic                                flash_readdatavalid,
  output logic [narrator_pkg::sample_w-1:0]   sample_out,
  output logic                                sample_valid,
  output logic                                busy,
  output logic                                done,
  output logic [rate_pkg::div_w-1:0]          rate_divisor
);

  logic tick;
  logic advance;
  logic byte_last;

  // Word requests and returned words
  word_fetch_if fetch_bus ();

  // ==============================
  // Flash side
  // ==============================

  flash_reader u_flash_reader (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .fetch               (fetch_bus.reader),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  sample_unpacker u_sample_unpacker (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .fetch        (fetch_bus.sink),
    .advance      (advance),
    .byte_last    (byte_last),
    .sample_out   (sample_out),
    .sample_valid (sample_valid)
  );

  // ==============================
  // Rate and control
  // ==============================

  sample_rate_timer u_sample_rate_timer (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .speed_up   (speed_up),
    .speed_down (speed_down),
    .speed_rst  (speed_rst),
    .tick       (tick),
    .divisor    (rate_divisor)
  );

  playback_fsm u_playback_fsm (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .play        (play),
    .phoneme_sel (phoneme_sel),
    .tick        (tick),
    .fetch       (fetch_bus.requester),
    .advance     (advance),
    .byte_last   (byte_last),
    .busy        (busy),
    .done        (done)
  );

endmodule

//--- design/playback_fsm.sv
`timescale 1ns/1ps

module playback_fsm (
  input  logic                                CLK_50M,
  input  logic                                arst_n,
  input  logic                                play,
  input  logic [narrator_pkg::phoneme_w-1:0]  phoneme_sel,
  input  logic                                tick,
  word_fetch_if.requester                     fetch,
  output logic                                advance,
  input  logic                                byte_last,
  output logic                                busy,
  output logic                                done
);

  enum logic [2:0] {
    st_idle,
    st_fetch,
    st_wait_word,
    st_play_bytes,
    st_finish
  } state;

  logic [narrator_pkg::addr_w-1:0]                 cur_addr;
  logic [narrator_pkg::addr_w-1:0]                 end_addr;
  logic [$clog2(narrator_pkg::phoneme_count)-1:0]  sel_idx;
  logic                                            silent;
  logic                                            start_play;
  logic                                            word_done;
  logic                                            last_word;

  // Table lookup, out of range selects are silence
  assign sel_idx = phoneme_sel[$clog2(narrator_pkg::phoneme_count)-1:0];
  assign silent  = (int'(phoneme_sel) >= narrator_pkg::phoneme_count);

  assign start_play = (state == st_idle) && play;
  assign last_word  = (cur_addr == end_addr);

  // Ticks outside play_bytes are dropped
  assign advance   = (state == st_play_bytes) && tick;
  assign word_done = advance && byte_last;

  assign fetch.req  = (state == st_fetch);
  assign fetch.addr = cur_addr;

  assign busy = (state != st_idle);
  assign done = (state == st_finish);

  // ==============================
  // State sequencing
  // ==============================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= st_idle;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (play)
            state <= silent ? st_finish : st_fetch;
        end
        st_fetch:
        begin
          state <= st_wait_word;
        end
        st_wait_word:
        begin
          if (fetch.word_valid)
            state <= st_play_bytes;
        end
        st_play_bytes:
        begin
          // Top byte sent, either next word or finished
          if (word_done)
            state <= last_word ? st_finish : st_fetch;
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Word address walk from start to end
  always_ff @(posedge CLK_50M)
  begin
    if (start_play)
    begin
      cur_addr <= narrator_pkg::phoneme_start[sel_idx];
      end_addr <= narrator_pkg::phoneme_end[sel_idx];
    end
    else if (word_done && !last_word)
    begin
      cur_addr <= cur_addr + 1'b1;
    end
  end

  // One outstanding fetch at a time, its word only returns while awaited
  a_word_in_wait: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    fetch.word_valid |-> state == st_wait_word);

endmodule

//--- design/sample_rate_timer.sv
`timescale 1ns/1ps

module sample_rate_timer (
  input  logic                          CLK_50M,
  input  logic                          arst_n,
  input  logic                          speed_up,
  input  logic                          speed_down,
  input  logic                          speed_rst,
  output logic                          tick,
  output logic [rate_pkg::div_w-1:0]    divisor
);

  logic [rate_pkg::div_w-1:0] divisor_next;
  logic [rate_pkg::div_w-1:0] count;
  logic                       speed_event;

  assign speed_event = speed_up || speed_down || speed_rst;

  // ==============================
  // Saturating divisor update
  // ==============================

  always_comb
  begin
    divisor_next = divisor;
    if (speed_rst)
    begin
      divisor_next = rate_pkg::default_divisor;
    end
    else if (speed_up)
    begin
      // Smaller divisor plays faster
      if (divisor < rate_pkg::min_divisor + rate_pkg::divisor_step)
        divisor_next = rate_pkg::min_divisor;
      else
        divisor_next = divisor - rate_pkg::divisor_step;
    end
    else if (speed_down)
    begin
      if (divisor > rate_pkg::max_divisor - rate_pkg::divisor_step)
        divisor_next = rate_pkg::max_divisor;
      else
        divisor_next = divisor + rate_pkg::divisor_step;
    end
  end

  // Down counter, one tick per divisor cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      divisor <= rate_pkg::default_divisor;
      count   <= rate_pkg::default_divisor - 1'b1;
      tick    <= 1'b0;
    end
    else if (speed_event)
    begin
      // New rate restarts the period
      divisor <= divisor_next;
      count   <= divisor_next - 1'b1;
      tick    <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= divisor - 1'b1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

  a_divisor_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    divisor >= rate_pkg::min_divisor && divisor <= rate_pkg::max_divisor);

endmodule

//--- design/sample_unpacker.sv
`timescale 1ns/1ps

module sample_unpacker (
  input  logic                               CLK_50M,
  input  logic                               arst_n,
  word_fetch_if.sink                         fetch,
  input  logic                               advance,
  output logic                               byte_last,
  output logic [narrator_pkg::sample_w-1:0]  sample_out,
  output logic                               sample_valid
);

  logic [narrator_pkg::word_w-1:0]      word_q;
  logic [narrator_pkg::byte_idx_w-1:0]  byte_idx;

  // Index sits on the top byte of the word
  assign byte_last = (byte_idx == narrator_pkg::byte_idx_w'(narrator_pkg::bytes_per_word - 1));

  // ==============================
  // Byte index and valid strobe
  // ==============================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      byte_idx     <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= advance;
      if (fetch.word_valid)
      begin
        byte_idx <= '0;
      end
      else if (advance)
      begin
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

  // Word store and byte select, least significant first
  always_ff @(posedge CLK_50M)
  begin
    if (fetch.word_valid)
    begin
      word_q <= fetch.word;
    end
    if (advance)
    begin
      sample_out <= word_q[byte_idx*narrator_pkg::sample_w +: narrator_pkg::sample_w];
    end
  end

  // FSM only advances once the word has landed
  a_no_advance_on_load: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    !(advance && fetch.word_valid));

endmodule

//--- design/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                             CLK_50M,
  input  logic                             arst_n,
  word_fetch_if.reader                     fetch,
  output logic                             flash_read,
  output logic [narrator_pkg::addr_w-1:0]  flash_address,
  input  logic                             flash_waitrequest,
  input  logic [narrator_pkg::word_w-1:0]  flash_readdata,
  input  logic                             flash_readdatavalid
);

  // Read issued, data not yet returned
  logic pending;

  // ==============================
  // Bus handshake
  // ==============================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      flash_read       <= 1'b0;
      pending          <= 1'b0;
      fetch.word_valid <= 1'b0;
    end
    else
    begin
      fetch.word_valid <= 1'b0;
      if (fetch.req)
      begin
        flash_read <= 1'b1;
        pending    <= 1'b1;
      end
      // Held through waitrequest, dropped once accepted
      else if (flash_read && !flash_waitrequest)
      begin
        flash_read <= 1'b0;
      end
      if (pending && flash_readdatavalid)
      begin
        pending          <= 1'b0;
        fetch.word_valid <= 1'b1;
      end
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (fetch.req)
    begin
      flash_address <= fetch.addr;
    end
    if (pending && flash_readdatavalid)
    begin
      fetch.word <= flash_readdata;
    end
  end

  // A stalled read keeps its address and stays asserted
  a_addr_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

endmodule

//--- design/word_fetch_if.sv
`timescale 1ns/1ps

interface word_fetch_if;

  // Request side, one pulse per word
  logic                             req;
  logic [narrator_pkg::addr_w-1:0]  addr;

  // Returned word, valid with word_valid
  logic [narrator_pkg::word_w-1:0]  word;
  logic                             word_valid;

  modport requester (
    output req,
    output addr,
    input  word_valid
  );

  modport reader (
    input  req,
    input  addr,
    output word,
    output word_valid
  );

  modport sink (
    input  word,
    input  word_valid
  );

endinterface

//--- design/rate_pkg.sv
package rate_pkg;

  // ==============================
  // Sample-rate divisor
  // ==============================

  localparam int div_w = 16;

  // About 7.2 kHz from the 50 MHz clock
  localparam logic [div_w-1:0] default_divisor = 16'd6944;

  // Change per speed event, in clock cycles
  localparam logic [div_w-1:0] divisor_step = 16'd100;

  // Fastest and slowest allowed rates
  localparam logic [div_w-1:0] min_divisor = 16'd1000;
  localparam logic [div_w-1:0] max_divisor = 16'd60000;

endpackage

//--- design/narrator_pkg.sv
package narrator_pkg;

  // ==============================
  // Flash word and sample widths
  // ==============================

  // One flash word holds four 8-bit samples
  localparam int word_w = 32;

  // Flash is addressed in whole words
  localparam int addr_w = 23;

  localparam int sample_w = 8;
  localparam int bytes_per_word = 4;

  // Byte position within a word
  localparam int byte_idx_w = 2;

  // ==============================
  // Phoneme address table
  // ==============================

  localparam int phoneme_w = 8;
  localparam int phoneme_count = 8;

  // First word of each phoneme
  localparam logic [addr_w-1:0] phoneme_start [phoneme_count] = '{
    23'h00_0100,
    23'h00_0200,
    23'h00_0300,
    23'h00_0400,
    23'h00_0500,
    23'h00_0600,
    23'h00_0700,
    23'h00_0800
  };

  // Last word of each phoneme, inclusive
  // Lengths run 3, 2, 1 words and repeat
  localparam logic [addr_w-1:0] phoneme_end [phoneme_count] = '{
    23'h00_0102,
    23'h00_0201,
    23'h00_0300,
    23'h00_0402,
    23'h00_0501,
    23'h00_0600,
    23'h00_0702,
    23'h00_0801
  };

  // Selects at or above phoneme_count play as silence

endpackage
